// ==== board_io.sv ====
/*
 * Board side glue: core reset from rst_i and the button,
 * and the registered LED mux between GPIO and debug view.
 */
`timescale 1ns/1ps
`include "borg_soc_consts.svh"

module board_io (
	input  logic       clk,
	input  logic       rst_i,
	input  logic [3:0] btn_i,
	input  logic [7:0] sw_i,
	input  logic [7:0] gpo_led_i,
	input  logic       irq_i,
	input  logic       bus_cyc_i,
	input  logic       bus_stb_i,
	input  logic       bus_ack_i,
	output logic       core_rst_o,
	output logic [7:0] led_o
);

	logic [`RST_SYNC_DEPTH-1:0] btn_sync;
	logic [7:0]                 debug_led;

	// Button synchronizer, oldest sample at the top
	always_ff @(posedge clk) begin
		if (rst_i) begin
			btn_sync <= '0;
		end else begin
			btn_sync <= {btn_sync[`RST_SYNC_DEPTH-2:0], btn_i[0]};
		end
	end

	// sw[1] high masks the button
	assign core_rst_o = rst_i || (!sw_i[1] && btn_sync[`RST_SYNC_DEPTH-1]);

	// Debug view of reset, irq and bus activity
	assign debug_led = {core_rst_o, irq_i, bus_cyc_i && bus_stb_i, bus_ack_i, btn_i};

	always_ff @(posedge clk) begin
		if (rst_i)
			led_o <= '0;
		else
			led_o <= sw_i[1] ? gpo_led_i : debug_led;
	end

endmodule

// ==== borg_soc.f ====
+incdir+.
borg_soc_pkg.sv
wb_bus_if.sv
bus_decoder.sv
gpio_port.sv
tick_timer.sv
board_io.sv
borg_soc.sv
soc_checker.sv
tb_borg_soc.sv

// ==== borg_soc.sv ====
/*
 * Top level of the bus-side SoC, driven by an external Wishbone master.
 * Holds the board glue, the decoder, the GPIO block and the timer.
 */
`timescale 1ns/1ps
`include "borg_soc_consts.svh"

module borg_soc (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic [3:0]            btn_i,
	input  logic [7:0]            sw_i,
	// Wishbone master port
	input  logic [`BUS_ADR_W-1:0] wb_adr_i,
	input  logic [`BUS_DAT_W-1:0] wb_dat_i,
	input  logic                  wb_we_i,
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	output logic [`BUS_DAT_W-1:0] wb_dat_o,
	output logic                  wb_ack_o,
	// Board pins
	output logic [7:0]            led_o,
	output logic [5:0]            disp_a_o,
	output logic [7:0]            disp_b_o,
	output logic                  disp_b_oe_o,
	input  logic [7:0]            disp_b_i,
	output logic                  timer_irq_o
);

	logic       core_rst;
	logic [7:0] gpo_led;

	wb_bus_if m_bus ();
	wb_bus_if tmr_bus ();
	wb_bus_if gio_bus ();

	// External master onto the decoder input
	assign m_bus.adr   = wb_adr_i;
	assign m_bus.dat_w = wb_dat_i;
	assign m_bus.we    = wb_we_i;
	assign m_bus.cyc   = wb_cyc_i;
	assign m_bus.stb   = wb_stb_i;
	assign wb_dat_o    = m_bus.dat_r;
	assign wb_ack_o    = m_bus.ack;

	board_io u_board_io (
		.clk        (clk),
		.rst_i      (rst_i),
		.btn_i      (btn_i),
		.sw_i       (sw_i),
		.gpo_led_i  (gpo_led),
		.irq_i      (timer_irq_o),
		.bus_cyc_i  (wb_cyc_i),
		.bus_stb_i  (wb_stb_i),
		.bus_ack_i  (wb_ack_o),
		.core_rst_o (core_rst),
		.led_o      (led_o)
	);

	bus_decoder u_bus_decoder (
		.clk   (clk),
		.rst_i (core_rst),
		.m     (m_bus.slave),
		.tmr   (tmr_bus.master),
		.gio   (gio_bus.master)
	);

	gpio_port u_gpio_port (
		.clk         (clk),
		.rst_i       (core_rst),
		.bus         (gio_bus.slave),
		.gpo_led_o   (gpo_led),
		.disp_a_o    (disp_a_o),
		.disp_b_o    (disp_b_o),
		.disp_b_oe_o (disp_b_oe_o),
		.disp_b_i    (disp_b_i)
	);

	tick_timer u_tick_timer (
		.clk   (clk),
		.rst_i (core_rst),
		.bus   (tmr_bus.slave),
		.irq_o (timer_irq_o)
	);

endmodule

// ==== borg_soc_cases.txt ====
# name op addr data sw disp_b_i expected, numbers in hex
# read/poll: data is the mask; pins: addr picks led/disp_a/disp_b/oe/irq, data drives btn_i
led_wr       write E0040000 FFFFFFA5 02 00 00000000
led_rd       read  E0040000 FFFFFFFF 02 00 000000A5
led_pin      pins  00000000 00000000 02 00 000000A5
dispa_wr     write E0040004 0000007F 02 00 00000000
dispa_rd     read  E0040004 FFFFFFFF 02 00 0000003F
dispa_pin    pins  00000001 00000000 02 00 0000003F
dispb_wr     write E0040008 0000015A 02 00 00000000
dispb_pin    pins  00000002 00000000 02 00 0000005A
oe_wr        write E004000C 00000001 02 00 00000000
oe_pin       pins  00000003 00000000 02 00 00000001
dispb_rd     read  E0040008 FFFFFFFF 02 C3 000000C3
os_cmp_wr    write E0020004 00000040 02 00 00000000
os_ctrl_wr   write E0020000 00000001 02 00 00000000
os_poll      poll  E0020000 00000004 02 00 00000004
os_irq_pin   pins  00000004 00000000 02 00 00000001
os_ctrl_rd   read  E0020000 FFFFFFFF 02 00 00000004
os_count_rd  read  E0020008 FFFFFFFF 02 00 00000040
os_clr_wr    write E0020000 00000000 02 00 00000000
os_irq_clr   pins  00000004 00000000 02 00 00000000
ar_cmp_wr    write E0020004 0000001F 02 00 00000000
ar_ctrl_wr   write E0020000 00000003 02 00 00000000
ar_poll      poll  E0020000 00000004 02 00 00000004
ar_en_rd     read  E0020000 00000003 02 00 00000003
ar_count_rd  read  E0020008 FFFFFFE0 02 00 00000000
ar_stop_wr   write E0020000 00000000 02 00 00000000
nomap_rd     read  00000010 FFFFFFFF 02 00 00000000
nomap_wr     write 00000000 000000FF 02 00 00000000
nomap_led_rd read  E0040000 FFFFFFFF 02 00 000000A5
dbg_pin      pins  00000000 0000000E 00 00 0000000E
keep_press   press 00000000 00000001 02 00 00000000
keep_led_rd  read  E0040000 FFFFFFFF 02 00 000000A5
rst_press    press 00000000 00000001 00 00 00000000
rst_led_rd   read  E0040000 FFFFFFFF 00 00 00000000
rst_a_rd     read  E0040004 FFFFFFFF 00 00 00000000
rst_oe_pin   pins  00000003 00000000 00 00 00000000

// ==== borg_soc_consts.svh ====
/*
 * Shared constants for the bus side of the SoC.
 * Included by the interface, the decoder, the peripherals and the top level.
 */
`ifndef BORG_SOC_CONSTS_SVH
`define BORG_SOC_CONSTS_SVH

// Bus widths
`define BUS_ADR_W 32
`define BUS_DAT_W 32

// --------------------------------------------------
// Slot decode, upper address bits
// --------------------------------------------------
`define SLOT_HI 31
`define SLOT_LO 17
`define SLOT_TIMER 15'h7001
`define SLOT_GPIO 15'h7002

// Word register index inside a slot
`define REG_IDX_HI 3
`define REG_IDX_LO 2

// Flip-flops in the push button synchronizer
`define RST_SYNC_DEPTH 2

`endif

// ==== borg_soc_pkg.sv ====
/*
 * Types shared by the decoder and the peripherals.
 * Imported by wildcard in the module headers that need them.
 */
package borg_soc_pkg;

	// Decoder result, one per reachable target
	typedef enum logic [1:0] {
		SLOT_NONE = 2'd0,
		SLOT_TMR  = 2'd1,
		SLOT_GIO  = 2'd2
	} bus_slot_e;

	// Timer word registers
	typedef enum logic [1:0] {
		TMR_CTRL    = 2'd0,
		TMR_COMPARE = 2'd1,
		TMR_COUNT   = 2'd2
	} timer_reg_e;

	// GPIO word registers
	typedef enum logic [1:0] {
		GIO_LED       = 2'd0,
		GIO_DISP_A    = 2'd1,
		GIO_DISP_B    = 2'd2,
		GIO_DISP_B_OE = 2'd3
	} gpio_reg_e;

endpackage

// ==== bus_decoder.sv ====
/*
 * Address decoder for the external Wishbone master.
 * Routes each cycle to the timer or the GPIO block by slot code and
 * answers unmapped addresses itself with zero data.
 */
`timescale 1ns/1ps
`include "borg_soc_consts.svh"

module bus_decoder import borg_soc_pkg::*; (
	input logic     clk,
	input logic     rst_i,
	wb_bus_if.slave  m,
	wb_bus_if.master tmr,
	wb_bus_if.master gio
);

	bus_slot_e slot;
	logic      none_ack;

	// --------------------------------------------------
	// Slot select from the upper address bits
	// --------------------------------------------------
	always_comb begin
		case (m.adr[`SLOT_HI:`SLOT_LO])
			`SLOT_TIMER: slot = SLOT_TMR;
			`SLOT_GPIO:  slot = SLOT_GIO;
			default:     slot = SLOT_NONE;
		endcase
	end

	// Request fans out, only stb is qualified
	assign tmr.adr   = m.adr;
	assign tmr.dat_w = m.dat_w;
	assign tmr.we    = m.we;
	assign tmr.cyc   = m.cyc;
	assign tmr.stb   = m.stb && (slot == SLOT_TMR);

	assign gio.adr   = m.adr;
	assign gio.dat_w = m.dat_w;
	assign gio.we    = m.we;
	assign gio.cyc   = m.cyc;
	assign gio.stb   = m.stb && (slot == SLOT_GIO);

	// Unmapped cycle, same one-cycle latency as a peripheral
	always_ff @(posedge clk) begin
		if (rst_i) begin
			none_ack <= 1'b0;
		end else begin
			none_ack <= m.cyc && m.stb && (slot == SLOT_NONE) && !none_ack;
		end
	end

	// Return path, address is held until ack so slot stays valid
	always_comb begin
		case (slot)
			SLOT_TMR: m.dat_r = tmr.dat_r;
			SLOT_GIO: m.dat_r = gio.dat_r;
			default:  m.dat_r = '0;
		endcase
	end

	assign m.ack = tmr.ack || gio.ack || none_ack;

	// Only one peripheral answers at a time
	a_one_slave_ack: assert property (@(posedge clk) disable iff (rst_i)
		!(tmr.ack && gio.ack));

	// Ack to the master is a single-cycle pulse
	a_ack_pulse: assert property (@(posedge clk) disable iff (rst_i)
		m.ack |=> !m.ack);

endmodule

// ==== gpio_port.sv ====
/*
 * 8-bit GPIO block on the Wishbone bus.
 * Drives the LED source, display port A and display port B with its
 * output enable; a read of the port B register samples the pins.
 */
`timescale 1ns/1ps
`include "borg_soc_consts.svh"

module gpio_port import borg_soc_pkg::*; (
	input  logic       clk,
	input  logic       rst_i,
	wb_bus_if.slave    bus,
	output logic [7:0] gpo_led_o,
	output logic [5:0] disp_a_o,
	output logic [7:0] disp_b_o,
	output logic       disp_b_oe_o,
	input  logic [7:0] disp_b_i
);

	gpio_reg_e  reg_idx;
	logic       ack_q;
	logic       req;
	logic [7:0] led_q;
	logic [5:0] disp_a_q;
	logic [7:0] disp_b_q;
	logic [7:0] disp_b_oe_q;

	assign reg_idx = gpio_reg_e'(bus.adr[`REG_IDX_HI:`REG_IDX_LO]);

	// New request, not yet answered
	assign req = bus.cyc && bus.stb && !ack_q;

	// --------------------------------------------------
	// Ack and register writes
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			ack_q       <= 1'b0;
			led_q       <= '0;
			disp_a_q    <= '0;
			disp_b_q    <= '0;
			disp_b_oe_q <= '0;
		end else begin
			ack_q <= req;
			if (req && bus.we) begin
				// Low bits only, rest of the word dropped
				case (reg_idx)
					GIO_LED:       led_q       <= bus.dat_w[7:0];
					GIO_DISP_A:    disp_a_q    <= bus.dat_w[5:0];
					GIO_DISP_B:    disp_b_q    <= bus.dat_w[7:0];
					GIO_DISP_B_OE: disp_b_oe_q <= bus.dat_w[7:0];
					default:       ;
				endcase
			end
		end
	end

	// Readback, port B returns the pins not the register
	always_comb begin
		case (reg_idx)
			GIO_LED:       bus.dat_r = {{(`BUS_DAT_W-8){1'b0}}, led_q};
			GIO_DISP_A:    bus.dat_r = {{(`BUS_DAT_W-6){1'b0}}, disp_a_q};
			GIO_DISP_B:    bus.dat_r = {{(`BUS_DAT_W-8){1'b0}}, disp_b_i};
			GIO_DISP_B_OE: bus.dat_r = {{(`BUS_DAT_W-8){1'b0}}, disp_b_oe_q};
			default:       bus.dat_r = '0;
		endcase
	end

	assign bus.ack     = ack_q;
	assign gpo_led_o   = led_q;
	assign disp_a_o    = disp_a_q;
	assign disp_b_o    = disp_b_q;
	assign disp_b_oe_o = disp_b_oe_q[0];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SoC testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_borg_soc -f borg_soc.f -o sim_borg_soc
out=$(./obj_dir/sim_borg_soc)
echo "$out"
if echo "$out" | grep -qF 'All tests passed!'; then
	exit 0
fi
exit 1

// ==== soc_checker.sv ====
/*
 * Checker for the SoC testbench.
 * Watches the bus handshake on its own and compares the values that
 * the testbench hands over; keeps the counts for the closing summary.
 */
`timescale 1ns/1ps

module soc_checker (
	input logic clk,
	input logic rst_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_ack_i
);

	int   checks         = 0;
	int   check_errors   = 0;
	int   monitor_errors = 0;
	logic ack_prev       = 1'b0;
	logic req_prev       = 1'b0;
	logic pend_prev      = 1'b0;

	// --------------------------------------------------
	// Handshake monitor, sampled on the rising edge
	// --------------------------------------------------
	always @(posedge clk) begin
		if (rst_i) begin
			ack_prev  <= 1'b0;
			req_prev  <= 1'b0;
			pend_prev <= 1'b0;
		end else begin
			// Ack is a single pulse
			if (wb_ack_i && ack_prev) begin
				$display("Bus ack stayed high for more than one cycle at %0t", $time);
				monitor_errors = monitor_errors + 1;
			end
			// Ack only follows a request seen one edge earlier
			if (wb_ack_i && !req_prev) begin
				$display("Bus ack came without a pending request at %0t", $time);
				monitor_errors = monitor_errors + 1;
			end
			// Unanswered request gets its ack on the very next edge
			if (pend_prev && !wb_ack_i) begin
				$display("Bus ack did not arrive one cycle after the request at %0t", $time);
				monitor_errors = monitor_errors + 1;
			end
			ack_prev  <= wb_ack_i;
			req_prev  <= wb_cyc_i && wb_stb_i;
			pend_prev <= wb_cyc_i && wb_stb_i && !wb_ack_i;
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			check_errors++;
			$display("FAIL %s: expected %08h, actual %08h", name, expected, actual);
		end
	endtask

	task automatic report_no_ack(input string name, input logic [31:0] adr);
		check_errors++;
		$display("Case %s got no ack from the bus at address %08h", name, adr);
	endtask

	task automatic report_problem(input string msg);
		check_errors++;
		$display("Error: %s", msg);
	endtask

	task automatic report_timeout(input int limit);
		$display("Run stopped at the limit of %0d cycles before all cases finished", limit);
	endtask

	function automatic int total_errors();
		return check_errors + monitor_errors;
	endfunction

	// One closing line with all counts
	task automatic print_summary();
		$display("Checks: %0d, value errors: %0d, handshake errors: %0d",
			checks, check_errors, monitor_errors);
	endtask

endmodule

// ==== tb_borg_soc.sv ====
/*
 * Testbench top for the bus-side SoC.
 * Reads borg_soc_cases.txt, plays the Wishbone master and the board pins,
 * and hands every observed value to soc_checker for comparison.
 */
`timescale 1ns/1ps
`include "borg_soc_consts.svh"

module tb_borg_soc;

	localparam int RESET_CYCLES = 10;
	localparam int CASE_CYCLES  = 200;
	localparam int ACK_WAIT     = 16;
	localparam int POLL_MAX     = 64;

	logic                  clk;
	logic                  rst_i;
	logic [3:0]            btn_i;
	logic [7:0]            sw_i;
	logic [`BUS_ADR_W-1:0] wb_adr_i;
	logic [`BUS_DAT_W-1:0] wb_dat_i;
	logic                  wb_we_i;
	logic                  wb_cyc_i;
	logic                  wb_stb_i;
	logic [`BUS_DAT_W-1:0] wb_dat_o;
	logic                  wb_ack_o;
	logic [7:0]            led_o;
	logic [5:0]            disp_a_o;
	logic [7:0]            disp_b_o;
	logic                  disp_b_oe_o;
	logic [7:0]            disp_b_i;
	logic                  timer_irq_o;
	int                    cycle_cnt = 0;
	int                    cycle_limit;
	string                 case_lines[$];

	borg_soc dut_i (.*);

	soc_checker u_checker (
		.clk      (clk),
		.rst_i    (rst_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_ack_i (wb_ack_o)
	);

	// 40 ns clock
	always #20 clk = ~clk;

	// --------------------------------------------------
	// Run limit, scaled by the number of cases
	// --------------------------------------------------
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			u_checker.report_timeout(cycle_limit);
			u_checker.print_summary();
			$display("Test failures found");
			$finish;
		end
	end

	// One classic cycle; starts on a falling edge, ends one idle cycle later
	task automatic bus_access(input logic we, input logic [31:0] adr,
			input logic [31:0] wdat, output logic [31:0] rdat, output logic acked);
		int waited;
		waited   = 0;
		acked    = 1'b0;
		rdat     = '0;
		wb_adr_i = adr;
		wb_dat_i = wdat;
		wb_we_i  = we;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		while (!acked && waited < ACK_WAIT) begin
			@(negedge clk);
			waited++;
			if (wb_ack_o) begin
				acked = 1'b1;
				rdat  = wb_dat_o;
			end
		end
		// Drop the request in the ack cycle
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		@(negedge clk);
	endtask

	// Pin group picked by the address column of a pins case
	function automatic logic [31:0] pin_value(input logic [31:0] group);
		case (group)
			32'd0:   return {24'd0, led_o};
			32'd1:   return {26'd0, disp_a_o};
			32'd2:   return {24'd0, disp_b_o};
			32'd3:   return {31'd0, disp_b_oe_o};
			32'd4:   return {31'd0, timer_irq_o};
			default: return '0;
		endcase
	endfunction

	initial begin
		int          fd;
		int          fields;
		int          polls;
		string       line;
		string       name;
		string       op;
		logic [31:0] adr;
		logic [31:0] data;
		logic [7:0]  sw;
		logic [7:0]  pins;
		logic [31:0] expected;
		logic [31:0] rdat;
		logic        acked;

		clk         = 1'b0;
		rst_i       = 1'b1;
		btn_i       = 4'd0;
		sw_i        = 8'd0;
		wb_adr_i    = '0;
		wb_dat_i    = '0;
		wb_we_i     = 1'b0;
		wb_cyc_i    = 1'b0;
		wb_stb_i    = 1'b0;
		disp_b_i    = 8'd0;
		cycle_limit = RESET_CYCLES + CASE_CYCLES;

		// Load the cases, comment lines start with #
		fd = $fopen("borg_soc_cases.txt", "r");
		if (fd == 0) begin
			u_checker.report_problem("cannot open borg_soc_cases.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				fields = $fgets(line, fd);
				if (line.len() > 0 && line.getc(0) != "#") begin
					fields = $sscanf(line, "%s %s %h %h %h %h %h",
						name, op, adr, data, sw, pins, expected);
					if (fields == 7)
						case_lines.push_back(line);
				end
			end
			$fclose(fd);
		end
		if (case_lines.size() == 0)
			u_checker.report_problem("no cases were loaded");
		cycle_limit = case_lines.size() * CASE_CYCLES + RESET_CYCLES;

		repeat (RESET_CYCLES) @(negedge clk);
		rst_i = 1'b0;
		@(negedge clk);

		// --------------------------------------------------
		// Case loop, everything driven on the falling edge
		// --------------------------------------------------
		foreach (case_lines[i]) begin
			fields = $sscanf(case_lines[i], "%s %s %h %h %h %h %h",
				name, op, adr, data, sw, pins, expected);
			sw_i     = sw;
			disp_b_i = pins;
			if (op == "write") begin
				bus_access(1'b1, adr, data, rdat, acked);
				if (!acked)
					u_checker.report_no_ack(name, adr);
			end else if (op == "read" || op == "poll") begin
				bus_access(1'b0, adr, '0, rdat, acked);
				polls = 1;
				// Poll repeats until every masked bit is set, for a bounded number of reads
				while (op == "poll" && acked && (rdat & data) != data &&
						polls < POLL_MAX) begin
					bus_access(1'b0, adr, '0, rdat, acked);
					polls++;
				end
				if (!acked)
					u_checker.report_no_ack(name, adr);
				else
					u_checker.check_value(name, expected, rdat & data);
			end else if (op == "pins") begin
				btn_i = data[3:0];
				// led_o is registered, let it settle
				repeat (2) @(negedge clk);
				u_checker.check_value(name, expected, pin_value(adr));
				btn_i = 4'd0;
			end else if (op == "press") begin
				btn_i = data[3:0];
				repeat (4) @(negedge clk);
				btn_i = 4'd0;
				// Synchronizer drains before the next access
				repeat (4) @(negedge clk);
			end else begin
				u_checker.report_problem(
					$sformatf("unknown operation %s in case %s", op, name));
			end
		end

		u_checker.print_summary();
		if (u_checker.total_errors() == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== tick_timer.sv ====
/*
 * Compare timer with one-shot and auto-reload modes.
 * Control bits: 0 enable, 1 auto-reload, 2 flag. The flag is the interrupt
 * and is cleared by any control write.
 */
`timescale 1ns/1ps
`include "borg_soc_consts.svh"

module tick_timer import borg_soc_pkg::*; (
	input  logic    clk,
	input  logic    rst_i,
	wb_bus_if.slave bus,
	output logic    irq_o
);

	timer_reg_e            reg_idx;
	logic                  ack_q;
	logic                  wr;
	logic                  ctrl_en;
	logic                  ctrl_ar;
	logic                  flag;
	logic [`BUS_DAT_W-1:0] compare;
	logic [`BUS_DAT_W-1:0] count;
	logic                  match;

	assign reg_idx = timer_reg_e'(bus.adr[`REG_IDX_HI:`REG_IDX_LO]);
	assign wr      = bus.cyc && bus.stb && !ack_q && bus.we;
	assign match   = ctrl_en && (count == compare);

	// --------------------------------------------------
	// Control, flag and ack
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			ack_q   <= 1'b0;
			ctrl_en <= 1'b0;
			ctrl_ar <= 1'b0;
			flag    <= 1'b0;
		end else begin
			ack_q <= bus.cyc && bus.stb && !ack_q;
			if (wr && reg_idx == TMR_CTRL) begin
				// Bus write wins over a match in the same cycle
				ctrl_en <= bus.dat_w[0];
				ctrl_ar <= bus.dat_w[1];
				flag    <= 1'b0;
			end else if (match) begin
				flag <= 1'b1;
				// One-shot stops here
				ctrl_en <= ctrl_ar;
			end
		end
	end

	// Compare and counter
	always_ff @(posedge clk) begin
		if (rst_i) begin
			compare <= '0;
			count   <= '0;
		end else if (wr && reg_idx == TMR_COMPARE) begin
			// New period restarts the count, keeps count <= compare
			compare <= bus.dat_w;
			count   <= '0;
		end else if (match) begin
			if (ctrl_ar)
				count <= '0;
		end else if (ctrl_en) begin
			count <= count + 1;
		end
	end

	always_comb begin
		case (reg_idx)
			TMR_CTRL:    bus.dat_r = {{(`BUS_DAT_W-3){1'b0}}, flag, ctrl_ar, ctrl_en};
			TMR_COMPARE: bus.dat_r = compare;
			TMR_COUNT:   bus.dat_r = count;
			default:     bus.dat_r = '0;
		endcase
	end

	assign bus.ack = ack_q;
	assign irq_o   = flag;

	// Counter stays inside the period while running
	a_count_in_range: assert property (@(posedge clk) disable iff (rst_i)
		ctrl_en |-> (count <= compare));

endmodule

// ==== wb_bus_if.sv ====
/*
 * Wishbone classic bus between the decoder and one peripheral.
 * The master side drives the request, the slave side returns data and ack.
 */
`timescale 1ns/1ps
`include "borg_soc_consts.svh"

interface wb_bus_if;
	logic [`BUS_ADR_W-1:0] adr;
	logic [`BUS_DAT_W-1:0] dat_w;
	logic [`BUS_DAT_W-1:0] dat_r;
	logic                  we;
	logic                  cyc;
	logic                  stb;
	logic                  ack;

	// Request side
	modport master (output adr, dat_w, we, cyc, stb, input dat_r, ack);

	// Peripheral side
	modport slave (input adr, dat_w, we, cyc, stb, output dat_r, ack);

endinterface
